//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module dma_tb --Mdir obj_dir -o dma_sim
	out=$$(./obj_dir/dma_sim); echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

//--- dv/ahb_mem_model.sv
// AHB slave memory model with random wait states and an error region at address bit 15.
`timescale 1ns/10ps
`default_nettype none

module ahb_mem_model #(
    parameter logic [31:0] SEED = 32'h9b64
) (
    input  logic             HCLK,
    input  dma_pkg::haddr_t  haddr,
    input  dma_pkg::htrans_t htrans,
    input  logic             hwrite,
    input  dma_pkg::hdata_t  hwdata,
    output logic             hready,
    output logic             hresp,
    output dma_pkg::hdata_t  hrdata
);
    import dma_pkg::*;

    hdata_t      mem [4096];
    logic [31:0] rng       = SEED;
    logic        filled    = 1'b0;
    logic        active    = 1'b0;
    logic        ready_r   = 1'b1;
    logic        resp_r    = 1'b0;
    hdata_t      rdata_r   = '0;
    haddr_t      ph_addr   = '0;
    logic        ph_write  = 1'b0;
    logic [1:0]  wait_left = 2'd0;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    assign hready = ready_r;
    assign hresp  = resp_r;
    assign hrdata = rdata_r;

    always @(posedge HCLK) begin : mem_cycle
        logic take;
        if (!filled) begin
            for (int i = 0; i < 4096; i++) begin
                mem[12'(i)] = xorshift32(SEED ^ 32'(i));  // Every word differs with its index.
            end
            filled = 1'b1;
        end
        take = htrans == HTRANS_NONSEQ && ready_r;  // Bus values as seen at this edge.
        if (active && ready_r) begin
            if (ph_write && !ph_addr[15]) begin
                mem[ph_addr[13:2]] = hwdata;
            end
            active = 1'b0;
        end
        if (take) begin
            active    = 1'b1;
            ph_addr   = haddr;
            ph_write  = hwrite;
            rng       = xorshift32(rng);
            wait_left = 2'(rng % 32'd3);
        end
        #2;
        if (active && wait_left != 2'd0) begin
            ready_r   = 1'b0;
            resp_r    = 1'b0;
            wait_left = wait_left - 2'd1;
        end else if (active) begin
            ready_r = 1'b1;
            resp_r  = ph_addr[15];  // Single cycle ERROR in the error region.
            rdata_r = ph_write ? '0 : mem[ph_addr[13:2]];
        end else begin
            ready_r = 1'b1;
            resp_r  = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- dv/dma_tb.sv
// DMA controller testbench with clock, bus grant, register programming, copy model and checks.
`timescale 1ns/10ps
`default_nettype none

module dma_tb;
    import dma_pkg::*;

    localparam int          N_CH       = 4;
    localparam logic [31:0] SEED       = 32'h9b64;
    localparam int          WAIT_LIMIT = 1000;

    logic             HCLK;
    logic             rst;
    haddr_t           haddr;
    logic             hwrite;
    htrans_t          htrans;
    hdata_t           hwdata;
    logic             hsel_reg;
    logic             hreadyin;
    hdata_t           hrdata_reg;
    logic             hbusreq;
    logic             hgrant;
    haddr_t           m_haddr;
    htrans_t          m_htrans;
    logic             m_hwrite;
    logic [2:0]       m_hsize;
    logic [2:0]       m_hburst;
    logic [3:0]       m_hprot;
    hdata_t           m_hwdata;
    hdata_t           m_hrdata;
    logic             m_hready;
    logic             m_hresp;
    logic [N_CH-1:0]  dma_req;
    logic [N_CH-1:0]  dma_ack;
    logic             dmaint;
    logic             dmaint_tc;
    logic             dmaint_err;

    hdata_t      model [4096];
    logic [31:0] rng;
    int unsigned errors;
    int unsigned timeouts;
    int unsigned ack_cnt [N_CH];
    int unsigned ack_base [N_CH];
    int unsigned exp_acks [N_CH];
    int unsigned multi_ack;
    int unsigned no_grant;
    int          src_w [N_CH];
    int          dst_w [N_CH];
    int          cnt [N_CH];
    hdata_t      rd;

    dma_top #(.N_CH(N_CH)) dut_i (
        .HCLK(HCLK), .rst(rst), .haddr(haddr), .hwrite(hwrite), .htrans(htrans),
        .hwdata(hwdata), .hsel_reg(hsel_reg), .hreadyin(hreadyin), .hrdata_reg(hrdata_reg),
        .hbusreq(hbusreq), .hgrant(hgrant), .m_haddr(m_haddr), .m_htrans(m_htrans),
        .m_hwrite(m_hwrite), .m_hsize(m_hsize), .m_hburst(m_hburst), .m_hprot(m_hprot),
        .m_hwdata(m_hwdata), .m_hrdata(m_hrdata), .m_hready(m_hready), .m_hresp(m_hresp),
        .dma_req(dma_req), .dma_ack(dma_ack), .dmaint(dmaint), .dmaint_tc(dmaint_tc),
        .dmaint_err(dmaint_err)
    );

    ahb_mem_model #(.SEED(SEED)) mem_i (
        .HCLK(HCLK), .haddr(m_haddr), .htrans(m_htrans), .hwrite(m_hwrite),
        .hwdata(m_hwdata), .hready(m_hready), .hresp(m_hresp), .hrdata(m_hrdata)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_below(input int n);
        rng = xorshift32(rng);
        return int'(rng % 32'(n));
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // One register slave transfer. Read data is valid in the cycle after the address phase.
    task automatic reg_access(input logic write, input haddr_t addr, input hdata_t wdata,
                              output hdata_t rdata);
        @(posedge HCLK);
        #2;
        haddr    = addr;
        hwrite   = write;
        htrans   = HTRANS_NONSEQ;
        hsel_reg = 1'b1;
        @(posedge HCLK);
        #2;
        htrans   = HTRANS_IDLE;
        hsel_reg = 1'b0;
        hwrite   = 1'b0;
        hwdata   = write ? wdata : '0;
        rdata    = hrdata_reg;
    endtask

    task automatic reg_write(input haddr_t addr, input hdata_t wdata);
        hdata_t unused;
        reg_access(1'b1, addr, wdata, unused);
        @(posedge HCLK);  // The write data phase completes at this edge.
        #2;
    endtask

    task automatic reg_read(input haddr_t addr, output hdata_t rdata);
        reg_access(1'b0, addr, '0, rdata);
    endtask

    function automatic haddr_t chan_reg(input int ch, input logic [3:0] offset);
        return haddr_t'(ch * 16) + haddr_t'(offset);
    endfunction

    task automatic program_channel(input int ch, input haddr_t src, input haddr_t dst,
                                   input int words);
        reg_write(chan_reg(ch, REG_SRC), src);
        reg_write(chan_reg(ch, REG_DST), dst);
        reg_write(chan_reg(ch, REG_COUNT), hdata_t'(words));
        reg_write(chan_reg(ch, REG_CTRL), 32'h1);
    endtask

    task automatic apply_copy(input int from_w, input int to_w, input int words);
        for (int k = 0; k < words; k++) begin
            model[12'(to_w + k)] = model[12'(from_w + k)];
        end
    endtask

    task automatic check_memory();
        for (int i = 0; i < 4096; i++) begin
            check_eq(mem_i.mem[12'(i)], model[12'(i)], $sformatf("memory word %0d", i));
        end
    endtask

    task automatic mark_acks();
        for (int c = 0; c < N_CH; c++) begin
            ack_base[c] = ack_cnt[c];
            exp_acks[c] = 0;
        end
    endtask

    task automatic check_acks();
        for (int c = 0; c < N_CH; c++) begin
            check_eq(ack_cnt[c] - ack_base[c], exp_acks[c], $sformatf("dma_ack count %0d", c));
        end
    endtask

    // Polls STATUS until all mask bits are set, optionally shuffling dma_req on the way.
    task automatic wait_status(input hdata_t mask, input logic shuffle_req, input string what);
        hdata_t st;
        logic   seen;
        int     polls;
        seen  = 1'b0;
        polls = 0;
        while (!seen && polls < WAIT_LIMIT) begin
            reg_read(haddr_t'(REG_STATUS), st);
            seen = (st & mask) == mask;
            if (shuffle_req) begin
                dma_req = N_CH'(rand_below(1 << N_CH));
            end
            polls++;
        end
        if (!seen) begin
            timeouts++;
            $display("Timeout: %s did not finish within %0d STATUS polls", what, WAIT_LIMIT);
        end
        repeat (3) @(posedge HCLK);  // Lets the last dma_ack reach the counters.
        #2;
    endtask

    initial begin
        HCLK = 1'b0;
        forever #20 HCLK = ~HCLK;
    end

    // Bus arbiter stand-in. A new grant delay is drawn while the bus is not requested.
    initial begin : grant_proc
        logic        req;
        logic [1:0]  delay;
        logic [31:0] gnt_rng;
        gnt_rng = xorshift32(SEED);
        delay   = 2'd0;
        hgrant  = 1'b0;
        forever begin
            @(posedge HCLK);
            req = hbusreq;
            #2;
            if (!req) begin
                gnt_rng = xorshift32(gnt_rng);
                delay   = gnt_rng[1:0];
                hgrant  = delay == 2'd0;  // Parked grant for a zero delay.
            end else if (delay != 2'd0) begin
                delay  = delay - 2'd1;
                hgrant = delay == 2'd0;
            end
        end
    end

    always @(posedge HCLK) begin
        if (rst) begin
            for (int c = 0; c < N_CH; c++) begin
                ack_cnt[c] <= 0;
            end
            multi_ack <= 0;
            no_grant  <= 0;
        end else begin
            for (int c = 0; c < N_CH; c++) begin
                ack_cnt[c] <= ack_cnt[c] + 32'(dma_ack[c]);
            end
            if ($countones(dma_ack) > 1) begin
                multi_ack <= multi_ack + 1;
            end
            if (m_htrans == HTRANS_NONSEQ && !hgrant) begin
                no_grant <= no_grant + 1;  // Address phase issued without owning the bus.
            end
        end
    end

    initial begin
        rst      = 1'b1;
        haddr    = '0;
        hwrite   = 1'b0;
        htrans   = HTRANS_IDLE;
        hwdata   = '0;
        hsel_reg = 1'b0;
        hreadyin = 1'b1;
        dma_req  = '0;
        errors   = 0;
        timeouts = 0;
        rng      = SEED;
        repeat (8) @(posedge HCLK);
        #2;
        rst = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            model[12'(i)] = mem_i.mem[12'(i)];
        end

        // Register read back and reset values.
        reg_read(haddr_t'(REG_STATUS), rd);
        check_eq(rd, 32'h0, "STATUS after reset");
        check_eq(32'(dmaint), 32'h0, "dmaint after reset");
        check_eq(32'(hbusreq), 32'h0, "hbusreq after reset");
        for (int k = 0; k < 3; k++) begin
            rng = xorshift32(rng);
            reg_write(chan_reg(1, 4'(4 * k)), rng);
            reg_read(chan_reg(1, 4'(4 * k)), rd);
            check_eq(rd, (k == 2) ? {16'h0, rng[15:0]} : rng, "channel 1 register read back");
        end
        reg_write(chan_reg(1, REG_CTRL), 32'h1);
        reg_read(chan_reg(1, REG_CTRL), rd);
        check_eq(rd, 32'h1, "channel 1 CTRL set");
        reg_write(chan_reg(1, REG_CTRL), 32'h0);
        reg_read(chan_reg(1, REG_CTRL), rd);
        check_eq(rd, 32'h0, "channel 1 CTRL cleared");

        // Single channel block copy.
        mark_acks();
        src_w[0]    = rand_below(200);
        dst_w[0]    = 2048 + rand_below(200);
        cnt[0]      = 1 + rand_below(8);
        exp_acks[0] = cnt[0];
        program_channel(0, haddr_t'(src_w[0] * 4), haddr_t'(dst_w[0] * 4), cnt[0]);
        dma_req = N_CH'(1);
        wait_status(32'h1, 1'b0, "channel 0 copy");
        dma_req = '0;
        apply_copy(src_w[0], dst_w[0], cnt[0]);
        check_memory();
        reg_read(chan_reg(0, REG_COUNT), rd);
        check_eq(rd, 32'h0, "channel 0 COUNT after copy");
        reg_read(chan_reg(0, REG_CTRL), rd);
        check_eq(rd, 32'h0, "channel 0 CTRL after copy");
        check_eq(32'(dmaint_tc), 32'h1, "dmaint_tc after copy");
        check_eq(32'(dmaint), 32'h1, "dmaint after copy");
        check_eq(32'(hbusreq), 32'h0, "hbusreq with the engine idle");
        check_acks();
        reg_write(haddr_t'(REG_STATUS), 32'h1);
        check_eq(32'(dmaint), 32'h0, "dmaint after tc clear");

        // All channels with random requests.
        mark_acks();
        for (int c = 0; c < N_CH; c++) begin
            src_w[c]    = c * 512 + rand_below(200);
            dst_w[c]    = 2048 + c * 256 + rand_below(200);
            cnt[c]      = 1 + rand_below(8);
            exp_acks[c] = cnt[c];
            program_channel(c, haddr_t'(src_w[c] * 4), haddr_t'(dst_w[c] * 4), cnt[c]);
        end
        wait_status(32'hF, 1'b1, "all channel copies");
        dma_req = '0;
        for (int c = 0; c < N_CH; c++) begin
            apply_copy(src_w[c], dst_w[c], cnt[c]);
        end
        check_memory();
        check_acks();
        reg_read(haddr_t'(REG_STATUS), rd);
        check_eq(rd, 32'hF, "STATUS after all copies");
        reg_write(haddr_t'(REG_STATUS), 32'hF);
        check_eq(32'(dmaint_tc), 32'h0, "dmaint_tc after clear");

        // Source block runs into the error region after two words.
        mark_acks();
        dst_w[2]    = 2048 + 512 + rand_below(200);
        cnt[2]      = 3 + rand_below(6);
        exp_acks[2] = 2;
        program_channel(2, 32'h7FF8, haddr_t'(dst_w[2] * 4), cnt[2]);
        dma_req = N_CH'(4);
        wait_status(32'h400, 1'b0, "channel 2 error stop");
        dma_req = '0;
        apply_copy(4094, dst_w[2], 2);
        check_memory();
        check_acks();
        reg_read(chan_reg(2, REG_COUNT), rd);
        check_eq(rd, 32'(cnt[2] - 2), "channel 2 COUNT after error");
        reg_read(chan_reg(2, REG_SRC), rd);
        check_eq(rd, 32'h8000, "channel 2 SRC after error");
        reg_read(chan_reg(2, REG_CTRL), rd);
        check_eq(rd, 32'h0, "channel 2 CTRL after error");
        reg_read(haddr_t'(REG_STATUS), rd);
        check_eq(rd, 32'h400, "STATUS after error");
        check_eq(32'(dmaint_err), 32'h1, "dmaint_err after error");
        check_eq(32'(dmaint_tc), 32'h0, "dmaint_tc after error");

        // Write one to clear.
        reg_write(haddr_t'(REG_STATUS), 32'h0);
        reg_read(haddr_t'(REG_STATUS), rd);
        check_eq(rd, 32'h400, "STATUS after writing zeros");
        reg_write(haddr_t'(REG_STATUS), 32'h0F0F);
        reg_read(haddr_t'(REG_STATUS), rd);
        check_eq(rd, 32'h0, "STATUS after clear");
        check_eq(32'(dmaint), 32'h0, "dmaint after clear");
        check_eq(32'(dmaint_err), 32'h0, "dmaint_err after clear");
        check_eq(32'(dmaint_tc), 32'h0, "dmaint_tc after final clear");
        check_eq(multi_ack, 32'h0, "cycles with more than one dma_ack");
        check_eq(no_grant, 32'h0, "address phases without hgrant");

        $display("Checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
source/dma_pkg.sv
source/dma_regs.sv
source/dma_chan_arb.sv
source/dma_engine.sv
source/dma_top.sv
dv/ahb_mem_model.sv
dv/dma_tb.sv

//--- source/dma_chan_arb.sv
// Round-robin selection of the next DMA channel to service.
`timescale 1ns/10ps
`default_nettype none

module dma_chan_arb #(
    parameter int N_CH = 4
) (
    input  logic                     HCLK,
    input  logic                     rst,
    input  logic [N_CH-1:0]          ch_req,
    input  logic                     busy,
    output logic                     start,
    output logic [dma_pkg::CH_W-1:0] start_ch
);
    import dma_pkg::*;

    logic [CH_W-1:0] last_q;
    logic [CH_W-1:0] pick;
    logic            pick_vld;

    always_comb begin
        int idx;
        pick     = last_q;
        pick_vld = 1'b0;
        // Walk down so the channel closest after the last one served wins.
        for (int i = N_CH; i >= 1; i--) begin
            idx = int'(last_q) + i;
            if (idx >= N_CH) begin
                idx = idx - N_CH;
            end
            if (ch_req[idx]) begin
                pick     = CH_W'(idx);
                pick_vld = 1'b1;
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (rst) begin
            start    <= 1'b0;
            start_ch <= '0;
            last_q   <= CH_W'(N_CH - 1);  // Channel 0 goes first after reset.
        end else begin
            start <= 1'b0;
            if (!busy && !start && pick_vld) begin
                start    <= 1'b1;
                start_ch <= pick;
                last_q   <= pick;
            end
        end
    end

    a_start_not_busy: assert property (@(posedge HCLK) disable iff (rst)
        start |-> !busy);

endmodule

`default_nettype wire

//--- source/dma_engine.sv
// AHB master FSM that reads one source word and writes it to the destination.
`timescale 1ns/10ps
`default_nettype none

module dma_engine (
    input  logic                     HCLK,
    input  logic                     rst,
    input  logic                     start,
    input  logic [dma_pkg::CH_W-1:0] start_ch,
    input  dma_pkg::dma_desc_t       desc,
    output logic                     busy,
    output dma_pkg::dma_result_t     result,
    output logic                     hbusreq,
    input  logic                     hgrant,
    output dma_pkg::haddr_t          m_haddr,
    output dma_pkg::htrans_t         m_htrans,
    output logic                     m_hwrite,
    output logic [2:0]               m_hsize,
    output logic [2:0]               m_hburst,
    output logic [3:0]               m_hprot,
    output dma_pkg::hdata_t          m_hwdata,
    input  dma_pkg::hdata_t          m_hrdata,
    input  logic                     m_hready,
    input  logic                     m_hresp
);
    import dma_pkg::*;

    eng_state_t      state;
    eng_state_t      state_nxt;
    haddr_t          src_q;
    haddr_t          dst_q;
    logic [CH_W-1:0] ch_q;
    hdata_t          hold_q;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (start) state_nxt = BUS_REQ;
            BUS_REQ: if (hgrant && m_hready) state_nxt = RD_ADDR;
            RD_ADDR: if (m_hready) state_nxt = RD_DATA;
            RD_DATA: begin
                if (m_hready) begin
                    state_nxt = (m_hresp == HRESP_ERROR) ? IDLE : WR_ADDR;  // Skip the write.
                end
            end
            WR_ADDR: if (m_hready) state_nxt = WR_DATA;
            WR_DATA: if (m_hready) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge HCLK) begin
        if (state == IDLE && start) begin
            src_q <= desc.src;
            dst_q <= desc.dst;
            ch_q  <= start_ch;
        end
        if (state == RD_DATA && m_hready) begin
            hold_q <= m_hrdata;
        end
    end

    // A word ends at the close of the write data phase, or early on a read error.
    always_comb begin
        result.done = 1'b0;
        result.err  = m_hresp == HRESP_ERROR;
        result.ch   = ch_q;
        if (m_hready) begin
            if (state == WR_DATA) begin
                result.done = 1'b1;
            end
            if (state == RD_DATA && m_hresp == HRESP_ERROR) begin
                result.done = 1'b1;
            end
        end
    end

    assign busy = state != IDLE;

    // The bus stays requested until the write address phase has gone out.
    assign hbusreq = state inside {BUS_REQ, RD_ADDR, RD_DATA, WR_ADDR};

    assign m_htrans = (state == RD_ADDR || state == WR_ADDR) ? HTRANS_NONSEQ : HTRANS_IDLE;
    assign m_haddr  = (state == WR_ADDR || state == WR_DATA) ? dst_q : src_q;
    assign m_hwrite = state == WR_ADDR || state == WR_DATA;
    assign m_hwdata = hold_q;
    assign m_hsize  = HSIZE_WORD;
    assign m_hburst = HBURST_SINGLE;
    assign m_hprot  = HPROT_DATA;

    a_no_trans_before_grant: assert property (@(posedge HCLK) disable iff (rst)
        (state == IDLE || state == BUS_REQ) |-> m_htrans == HTRANS_IDLE);

    // The arbiter only starts channels that still have words left.
    a_start_count: assert property (@(posedge HCLK) disable iff (rst)
        start |-> desc.count != '0);

endmodule

`default_nettype wire

//--- source/dma_pkg.sv
// Bus widths and types, descriptor and result structs, engine states and the register map.
`default_nettype none

package dma_pkg;

    localparam int HADDR_W    = 32;
    localparam int HDATA_W    = 32;
    localparam int COUNT_W    = 16;
    localparam int CH_W       = 3;  // Channel index width, so up to eight channels.
    localparam int REG_ADDR_W = 12;

    typedef logic [HADDR_W-1:0] haddr_t;
    typedef logic [HDATA_W-1:0] hdata_t;
    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [1:0]         htrans_t;

    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;

    localparam logic       HRESP_ERROR   = 1'b1;
    localparam logic [2:0] HSIZE_WORD    = 3'b010;
    localparam logic [2:0] HBURST_SINGLE = 3'b000;
    localparam logic [3:0] HPROT_DATA    = 4'b0011;  // Privileged data access.

    typedef struct packed {
        haddr_t src;
        haddr_t dst;
        count_t count;
    } dma_desc_t;

    typedef struct packed {
        logic            done;
        logic            err;
        logic [CH_W-1:0] ch;
    } dma_result_t;

    typedef enum logic [2:0] {
        IDLE,
        BUS_REQ,
        RD_ADDR,
        RD_DATA,
        WR_ADDR,
        WR_DATA
    } eng_state_t;

    // Offsets inside a 16 byte channel window.
    localparam logic [3:0] REG_SRC   = 4'h0;
    localparam logic [3:0] REG_DST   = 4'h4;
    localparam logic [3:0] REG_COUNT = 4'h8;
    localparam logic [3:0] REG_CTRL  = 4'hC;

    localparam logic [REG_ADDR_W-1:0] REG_STATUS = 12'h100;
    localparam int STATUS_ERR_LSB = 8;

endpackage

`default_nettype wire

//--- source/dma_regs.sv
// AHB register slave with per-channel descriptors, enables, status and interrupts.
`timescale 1ns/10ps
`default_nettype none

module dma_regs #(
    parameter int N_CH = 4
) (
    input  logic                 HCLK,
    input  logic                 rst,
    input  dma_pkg::haddr_t      haddr,
    input  logic                 hwrite,
    input  dma_pkg::htrans_t     htrans,
    input  dma_pkg::hdata_t      hwdata,
    input  logic                 hsel_reg,
    input  logic                 hreadyin,
    output dma_pkg::hdata_t      hrdata_reg,
    output dma_pkg::dma_desc_t   desc [N_CH],
    output logic [N_CH-1:0]      ch_ready,
    input  dma_pkg::dma_result_t result,
    output logic [N_CH-1:0]      dma_ack,
    output logic                 dmaint,
    output logic                 dmaint_tc,
    output logic                 dmaint_err
);
    import dma_pkg::*;

    logic [REG_ADDR_W-1:0] addr_q;
    logic                  accept;
    logic                  wr_q;
    logic                  rd_q;
    logic [N_CH-1:0]       en_q;
    logic [N_CH-1:0]       tc_q;
    logic [N_CH-1:0]       err_q;
    logic [N_CH-1:0]       done_hit;
    logic [N_CH-1:0]       wr_sel;
    logic                  win_hit;
    logic                  status_wr;
    hdata_t                rdata;
    logic [7:0]            en_all;

    assign accept = hsel_reg && hreadyin && htrans == HTRANS_NONSEQ;

    always_ff @(posedge HCLK) begin
        if (rst) begin
            wr_q <= 1'b0;
            rd_q <= 1'b0;
        end else begin
            wr_q <= accept && hwrite;
            rd_q <= accept && !hwrite;
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            addr_q <= haddr[REG_ADDR_W-1:0];  // Upper bits are already decoded into hsel_reg.
        end
    end

    assign win_hit   = addr_q[REG_ADDR_W-1:7] == '0;  // Channel windows sit below 0x80.
    assign status_wr = wr_q && addr_q == REG_STATUS;

    always_comb begin
        for (int i = 0; i < N_CH; i++) begin
            done_hit[i] = result.done && result.ch == CH_W'(i);
            wr_sel[i]   = wr_q && win_hit && addr_q[6:4] == CH_W'(i);
        end
    end

    always_ff @(posedge HCLK) begin
        for (int i = 0; i < N_CH; i++) begin
            if (done_hit[i] && !result.err) begin
                desc[i].src   <= desc[i].src + HADDR_W'(4);
                desc[i].dst   <= desc[i].dst + HADDR_W'(4);
                desc[i].count <= desc[i].count - COUNT_W'(1);
            end
            if (wr_sel[i]) begin
                case (addr_q[3:0])
                    REG_SRC:   desc[i].src   <= hwdata;
                    REG_DST:   desc[i].dst   <= hwdata;
                    REG_COUNT: desc[i].count <= hwdata[COUNT_W-1:0];
                    default:   ;
                endcase
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (rst) begin
            en_q    <= '0;
            tc_q    <= '0;
            err_q   <= '0;
            dma_ack <= '0;
        end else begin
            dma_ack <= done_hit & {N_CH{!result.err}};  // A failed word is not acknowledged.
            if (status_wr) begin
                tc_q  <= tc_q & ~hwdata[N_CH-1:0];
                err_q <= err_q & ~hwdata[STATUS_ERR_LSB +: N_CH];
            end
            for (int i = 0; i < N_CH; i++) begin
                if (done_hit[i] && result.err) begin
                    en_q[i]  <= 1'b0;
                    err_q[i] <= 1'b1;
                end else if (done_hit[i] && desc[i].count == COUNT_W'(1)) begin
                    en_q[i] <= 1'b0;  // Last word of the block.
                    tc_q[i] <= 1'b1;
                end
                if (wr_sel[i] && addr_q[3:0] == REG_CTRL) begin
                    en_q[i] <= hwdata[0];
                end
            end
        end
    end

    always_comb begin
        rdata = '0;
        if (addr_q == REG_STATUS) begin
            rdata[N_CH-1:0]               = tc_q;
            rdata[STATUS_ERR_LSB +: N_CH] = err_q;
        end
        for (int i = 0; i < N_CH; i++) begin
            if (win_hit && addr_q[6:4] == CH_W'(i)) begin
                case (addr_q[3:0])
                    REG_SRC:   rdata = desc[i].src;
                    REG_DST:   rdata = desc[i].dst;
                    REG_COUNT: rdata = HDATA_W'(desc[i].count);
                    REG_CTRL:  rdata = HDATA_W'(en_q[i]);
                    default:   rdata = '0;
                endcase
            end
        end
    end

    assign hrdata_reg = rd_q ? rdata : '0;

    always_comb begin
        for (int i = 0; i < N_CH; i++) begin
            ch_ready[i] = en_q[i] && desc[i].count != '0;
        end
    end

    assign dmaint_tc  = |tc_q;
    assign dmaint_err = |err_q;
    assign dmaint     = dmaint_tc || dmaint_err;

    assign en_all = 8'(en_q);

    // The engine only finishes words for channels that were still enabled when started.
    a_done_enabled: assert property (@(posedge HCLK) disable iff (rst)
        result.done |-> en_all[result.ch]);

endmodule

`default_nettype wire

//--- source/dma_top.sv
// DMA controller top level with register slave, channel arbiter and AHB master engine.
`timescale 1ns/10ps
`default_nettype none

module dma_top #(
    parameter int N_CH = 4
) (
    input  logic             HCLK,
    input  logic             rst,
    input  dma_pkg::haddr_t  haddr,
    input  logic             hwrite,
    input  dma_pkg::htrans_t htrans,
    input  dma_pkg::hdata_t  hwdata,
    input  logic             hsel_reg,
    input  logic             hreadyin,
    output dma_pkg::hdata_t  hrdata_reg,
    output logic             hbusreq,
    input  logic             hgrant,
    output dma_pkg::haddr_t  m_haddr,
    output dma_pkg::htrans_t m_htrans,
    output logic             m_hwrite,
    output logic [2:0]       m_hsize,
    output logic [2:0]       m_hburst,
    output logic [3:0]       m_hprot,
    output dma_pkg::hdata_t  m_hwdata,
    input  dma_pkg::hdata_t  m_hrdata,
    input  logic             m_hready,
    input  logic             m_hresp,
    input  logic [N_CH-1:0]  dma_req,
    output logic [N_CH-1:0]  dma_ack,
    output logic             dmaint,
    output logic             dmaint_tc,
    output logic             dmaint_err
);
    import dma_pkg::*;

    dma_desc_t       desc [N_CH];
    dma_desc_t       desc_sel;
    dma_result_t     result;
    logic [N_CH-1:0] ch_ready;
    logic            busy;
    logic            start;
    logic [CH_W-1:0] start_ch;

    always_comb begin
        desc_sel = '0;
        for (int i = 0; i < N_CH; i++) begin
            if (start_ch == CH_W'(i)) begin
                desc_sel = desc[i];
            end
        end
    end

    dma_regs #(.N_CH(N_CH)) regs_i (
        .HCLK       (HCLK),
        .rst        (rst),
        .haddr      (haddr),
        .hwrite     (hwrite),
        .htrans     (htrans),
        .hwdata     (hwdata),
        .hsel_reg   (hsel_reg),
        .hreadyin   (hreadyin),
        .hrdata_reg (hrdata_reg),
        .desc       (desc),
        .ch_ready   (ch_ready),
        .result     (result),
        .dma_ack    (dma_ack),
        .dmaint     (dmaint),
        .dmaint_tc  (dmaint_tc),
        .dmaint_err (dmaint_err)
    );

    dma_chan_arb #(.N_CH(N_CH)) arb_i (
        .HCLK     (HCLK),
        .rst      (rst),
        .ch_req   (ch_ready & dma_req),  // A channel competes only while armed and requested.
        .busy     (busy),
        .start    (start),
        .start_ch (start_ch)
    );

    dma_engine engine_i (
        .HCLK     (HCLK),
        .rst      (rst),
        .start    (start),
        .start_ch (start_ch),
        .desc     (desc_sel),
        .busy     (busy),
        .result   (result),
        .hbusreq  (hbusreq),
        .hgrant   (hgrant),
        .m_haddr  (m_haddr),
        .m_htrans (m_htrans),
        .m_hwrite (m_hwrite),
        .m_hsize  (m_hsize),
        .m_hburst (m_hburst),
        .m_hprot  (m_hprot),
        .m_hwdata (m_hwdata),
        .m_hrdata (m_hrdata),
        .m_hready (m_hready),
        .m_hresp  (m_hresp)
    );

endmodule

`default_nettype wire
